/* include/zxmem_params.svh */
`ifndef ZXMEM_PARAMS_SVH
`define ZXMEM_PARAMS_SVH

// ======================================================================
// CPU side
// ======================================================================

`define ZX_CPU_AW 16           // Z80 address bus
`define ZX_DW 8                // Z80 data bus

// ======================================================================
// Memory side
// ======================================================================

// Byte address into the 2MB physical map
`define ZX_PHYS_AW 21

`define ZX_SD_AW 20            // 16-bit word address
`define ZX_SD_DW 16

// Offset inside one 16K bank or ROM page
`define ZX_BANK_AW 14

// Upper three bits of every ROM address
`define ZX_ROM_REGION 3'b101

// Floating bus value for port reads
`define ZX_PORT_IDLE 8'hFF

`endif

/* list.f */
+incdir+include
logic/zxmem_pkg.sv
logic/bus_decode.sv
logic/page_regs.sv
logic/addr_map.sv
logic/sdram_port.sv
logic/zxmem_top.sv
sim/sdram_model.sv
sim/zxmem_props.sv
sim/tb_zxmem.sv

/* logic/addr_map.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module addr_map (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zxmem_pkg::tagged_op_t op_i,
	output zxmem_pkg::mem_req_t   req_o,
	output logic                  io_rd_o
);

	zxmem_pkg::page_state_t pg;
	logic [1:0]             slot;
	logic [`ZX_BANK_AW-1:0] off;
	logic [3:0]             rom_page;
	logic [2:0]             bank;
	logic                   is_rom;
	logic                   is_rd;
	logic                   is_wr;
	logic [`ZX_PHYS_AW-1:0] phys;

	assign pg   = op_i.page;
	assign slot = op_i.op.addr[15:14];
	assign off  = op_i.op.addr[`ZX_BANK_AW-1:0];

	assign is_rd = op_i.op.valid & (op_i.op.kind == zxmem_pkg::OP_MEM_RD);
	assign is_wr = op_i.op.valid & (op_i.op.kind == zxmem_pkg::OP_MEM_WR);

	// Four ROMs on +3, two on 128K, the last one on 48K
	assign rom_page = pg.plus3 ? {2'b10, pg.rom_sel} : {pg.zx48, 2'b11, pg.zx48 | pg.rom_sel[0]};

	always_comb begin
		if (pg.special) begin
			case (pg.special_cfg)
				2'd0: bank = {1'b0, slot};
				2'd1: bank = {1'b1, slot};
				2'd2: bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: begin
					case (slot)
						2'd0: bank = 3'd4;
						2'd1: bank = 3'd7;
						2'd2: bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (slot)
				2'd1: bank = 3'd5;
				2'd2: bank = 3'd2;
				default: bank = pg.ram_bank;   // Slot 0 goes to ROM anyway
			endcase
		end
	end

	assign is_rom = ~pg.special & (slot == 2'd0);
	assign phys = is_rom ? {`ZX_ROM_REGION, rom_page, off}
		: {{(`ZX_PHYS_AW - `ZX_BANK_AW - 3){1'b0}}, bank, off};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_o.valid <= 1'b0;
			io_rd_o     <= 1'b0;
		end else begin
			req_o.valid <= is_rd | is_wr;
			io_rd_o     <= op_i.op.valid & (op_i.op.kind == zxmem_pkg::OP_IO_RD);
		end
		req_o.we   <= is_wr & ~is_rom;   // ROM write becomes a bare done
		req_o.rd   <= is_rd;
		req_o.phys <= phys;
		req_o.data <= op_i.op.data;
	end

endmodule

/* logic/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
	input  logic                clk_sys,
	input  logic                reset,
	input  zxmem_pkg::cpu_bus_t cpu_bus_i,
	input  logic                mem_done_i,
	output zxmem_pkg::bus_op_t  op_o,
	output logic                cpu_ready_o
);

	zxmem_pkg::cpu_bus_t bus_q;      // Bus as sampled
	logic [3:0]          strb;
	logic [3:0]          strb_q;     // Previous strobe levels
	logic [3:0]          rise;
	logic                busy;
	zxmem_pkg::op_kind_e kind;

	// Bit order follows op_kind_e
	assign strb[0] = bus_q.mreq & bus_q.rd & ~bus_q.m1;
	assign strb[1] = bus_q.mreq & bus_q.wr & ~bus_q.m1;
	assign strb[2] = bus_q.iorq & bus_q.wr & ~bus_q.m1;
	assign strb[3] = bus_q.iorq & bus_q.rd & ~bus_q.m1;
	assign rise = strb & ~strb_q;

	always_comb begin
		if (rise[0])
			kind = zxmem_pkg::OP_MEM_RD;
		else if (rise[1])
			kind = zxmem_pkg::OP_MEM_WR;
		else if (rise[2])
			kind = zxmem_pkg::OP_IO_WR;
		else
			kind = zxmem_pkg::OP_IO_RD;
	end

	always_ff @(posedge clk_sys) begin
		bus_q <= cpu_bus_i;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strb_q     <= '0;
			busy       <= 1'b0;
			op_o.valid <= 1'b0;
		end else begin
			strb_q     <= strb;
			op_o.valid <= |rise;
			// Only memory cycles stall the CPU
			if (rise[0] | rise[1])
				busy <= 1'b1;
			else if (mem_done_i)
				busy <= 1'b0;
		end
		op_o.kind <= kind;
		op_o.addr <= bus_q.addr;
		op_o.data <= bus_q.dout;
	end

	assign cpu_ready_o = ~busy;

endmodule

/* logic/page_regs.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module page_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zxmem_pkg::mem_mode_e  mode_i,
	input  zxmem_pkg::bus_op_t    op_i,
	output zxmem_pkg::tagged_op_t op_o,
	output zxmem_pkg::ula_out_t   ula_o
);

	zxmem_pkg::page_state_t page_q;
	logic [`ZX_CPU_AW-1:0]  a;
	logic                   io_wr;
	logic                   blocked;
	logic                   sel_7ffd;
	logic                   sel_1ffd;
	logic                   sel_fe;

	assign a = op_i.addr;
	assign io_wr = op_i.valid & (op_i.kind == zxmem_pkg::OP_IO_WR);

	// Lock bit or 48K mode freezes both registers
	assign blocked = page_q.locked | page_q.zx48;

	// 7FFD, partial decode; +3 also wants A14
	assign sel_7ffd = io_wr & ~a[15] & ~a[1] & (a[14] | ~page_q.plus3) & ~blocked;

	// 1FFD exists on +3 only
	assign sel_1ffd = io_wr & page_q.plus3 & a[12] & ~a[13] & ~a[14] & ~a[15] & ~a[1]
		& ~blocked;

	assign sel_fe = io_wr & ~a[0];   // ULA answers every even port

	// ======================================================================
	// Paging registers
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_q       <= '0;
			page_q.zx48  <= (mode_i == zxmem_pkg::MODE_48);
			page_q.plus3 <= (mode_i == zxmem_pkg::MODE_PLUS3);
		end else begin
			if (sel_7ffd) begin
				page_q.ram_bank   <= op_i.data[2:0];
				page_q.scr        <= op_i.data[3];
				page_q.rom_sel[0] <= op_i.data[4];
				page_q.locked     <= op_i.data[5];
			end
			if (sel_1ffd) begin
				page_q.special     <= op_i.data[0];
				page_q.special_cfg <= op_i.data[2:1];
				page_q.rom_sel[1]  <= op_i.data[2];   // Shares bit 2 with config
			end
		end
	end

	// ======================================================================
	// ULA port FE
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_o <= '0;
		end else if (sel_fe) begin
			ula_o.border <= op_i.data[2:0];
			ula_o.mic    <= op_i.data[3];
			ula_o.ear    <= op_i.data[4];
		end
	end

	// Tag with the state before any write landing this same edge
	always_ff @(posedge clk_sys) begin
		if (reset)
			op_o.op.valid <= 1'b0;
		else
			op_o.op.valid <= op_i.valid;
		op_o.op.kind <= op_i.kind;
		op_o.op.addr <= op_i.addr;
		op_o.op.data <= op_i.data;
		op_o.page    <= page_q;
	end

endmodule

/* logic/sdram_port.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module sdram_port (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zxmem_pkg::mem_req_t   req_i,
	input  logic                  io_rd_i,
	output zxmem_pkg::sdram_bus_t sdram_o,
	input  logic                  sdram_ack_i,
	input  logic [`ZX_SD_DW-1:0]  sdram_q_i,
	output logic [`ZX_DW-1:0]     cpu_din_o,
	output logic                  mem_done_o
);

	logic pend;       // Request out, ack not back yet
	logic rd_q;
	logic lane_q;     // Odd byte of the word
	logic issue;
	logic drop;
	logic ack_seen;

	assign issue = req_i.valid & (req_i.we | req_i.rd);
	assign drop  = req_i.valid & ~req_i.we & ~req_i.rd;   // Discarded ROM write

	// Access done once ack has caught up with req
	assign ack_seen = pend & (sdram_ack_i == sdram_o.req);

	// ======================================================================
	// Handshake control
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sdram_o.req <= 1'b0;
			pend        <= 1'b0;
			mem_done_o  <= 1'b0;
		end else begin
			mem_done_o <= ack_seen | drop;
			if (issue) begin
				sdram_o.req <= ~sdram_o.req;
				pend        <= 1'b1;
			end else if (ack_seen) begin
				pend <= 1'b0;
			end
		end
	end

	// Request payload, moves with the req toggle
	always_ff @(posedge clk_sys) begin
		if (issue) begin
			sdram_o.we   <= req_i.we;
			sdram_o.addr <= req_i.phys[`ZX_PHYS_AW-1:1];
			sdram_o.ds   <= req_i.we ? {req_i.phys[0], ~req_i.phys[0]} : 2'b11;
			sdram_o.data <= {req_i.data, req_i.data};   // Same byte on both lanes
			rd_q         <= req_i.rd;
			lane_q       <= req_i.phys[0];
		end
	end

	// ======================================================================
	// Read data back to the CPU
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (ack_seen & rd_q)
			cpu_din_o <= lane_q ? sdram_q_i[15:8] : sdram_q_i[7:0];
		else if (io_rd_i)
			cpu_din_o <= `ZX_PORT_IDLE;   // No readable ports kept
	end

endmodule

/* logic/zxmem_pkg.sv */
`include "zxmem_params.svh"

package zxmem_pkg;

	typedef enum logic [1:0] {
		MODE_128   = 2'd0,
		MODE_48    = 2'd1,
		MODE_PLUS3 = 2'd2
	} mem_mode_e;

	typedef enum logic [1:0] {
		OP_MEM_RD = 2'd0,
		OP_MEM_WR = 2'd1,
		OP_IO_WR  = 2'd2,
		OP_IO_RD  = 2'd3
	} op_kind_e;

	// Z80 pins, strobes already active high
	typedef struct packed {
		logic [`ZX_CPU_AW-1:0] addr;
		logic [`ZX_DW-1:0]     dout;
		logic                  mreq;
		logic                  iorq;
		logic                  rd;
		logic                  wr;
		logic                  m1;
	} cpu_bus_t;

	typedef struct packed {
		logic                  valid;
		op_kind_e              kind;
		logic [`ZX_CPU_AW-1:0] addr;
		logic [`ZX_DW-1:0]     data;
	} bus_op_t;

	typedef struct packed {
		logic [2:0] ram_bank;    // 7FFD bits 2:0
		logic [1:0] rom_sel;     // {1FFD bit 2, 7FFD bit 4}
		logic       special;     // All-RAM mode
		logic [1:0] special_cfg;
		logic       locked;      // 7FFD bit 5
		logic       zx48;
		logic       plus3;
		logic       scr;         // Shadow screen select
		logic [1:0] spare;
	} page_state_t;

	typedef struct packed {
		bus_op_t     op;
		page_state_t page;
	} tagged_op_t;

	typedef struct packed {
		logic                   valid;
		logic                   we;
		logic                   rd;
		logic [`ZX_PHYS_AW-1:0] phys;
		logic [`ZX_DW-1:0]      data;
	} mem_req_t;

	// Toggle req/ack port
	typedef struct packed {
		logic                 req;
		logic                 we;
		logic [`ZX_SD_AW-1:0] addr;
		logic [1:0]           ds;
		logic [`ZX_SD_DW-1:0] data;
	} sdram_bus_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_out_t;

endpackage

/* logic/zxmem_top.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module zxmem_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zxmem_pkg::mem_mode_e  mode_i,
	input  zxmem_pkg::cpu_bus_t   cpu_bus_i,
	output logic [`ZX_DW-1:0]     cpu_din_o,
	output logic                  cpu_ready_o,
	output zxmem_pkg::ula_out_t   ula_o,
	output zxmem_pkg::sdram_bus_t sdram_o,
	input  logic                  sdram_ack_i,
	input  logic [`ZX_SD_DW-1:0]  sdram_q_i
);

	zxmem_pkg::bus_op_t    bus_op;
	zxmem_pkg::tagged_op_t tag_op;
	zxmem_pkg::mem_req_t   mem_req;
	logic                  io_rd;
	logic                  mem_done;   // Back from stage 4 to stage 1

	bus_decode u_bus_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_bus_i   (cpu_bus_i),
		.mem_done_i  (mem_done),
		.op_o        (bus_op),
		.cpu_ready_o (cpu_ready_o)
	);

	page_regs u_page_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mode_i  (mode_i),
		.op_i    (bus_op),
		.op_o    (tag_op),
		.ula_o   (ula_o)
	);

	addr_map u_addr_map (
		.clk_sys (clk_sys),
		.reset   (reset),
		.op_i    (tag_op),
		.req_o   (mem_req),
		.io_rd_o (io_rd)
	);

	sdram_port u_sdram_port (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req_i       (mem_req),
		.io_rd_i     (io_rd),
		.sdram_o     (sdram_o),
		.sdram_ack_i (sdram_ack_i),
		.sdram_q_i   (sdram_q_i),
		.cpu_din_o   (cpu_din_o),
		.mem_done_o  (mem_done)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_zxmem \
	-f list.f -o sim_zxmem

./obj_dir/sim_zxmem > run.log 2>&1 || true
cat run.log

if grep -q "TB FAILED" run.log; then
	exit 1
fi
grep -q "TB PASSED" run.log || exit 1

/* sim/sdram_model.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module sdram_model (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zxmem_pkg::sdram_bus_t sdram_i,
	input  logic                  slow_i,    // Adds a long stall to each access
	output logic                  ack_o,
	output logic [`ZX_SD_DW-1:0]  q_o
);

	logic [`ZX_SD_DW-1:0] mem [0:(1<<`ZX_SD_AW)-1];
	logic [31:0]          rng;
	logic [4:0]           cnt;
	logic                 busy;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] rom_byte(input logic [20:0] p);
		return p[7:0] ^ p[15:8] ^ {3'b000, p[20:16]};
	endfunction

	initial begin
		rng = 32'h37c21898;
		for (int i = 0; i < (1 << `ZX_SD_AW); i++)
			mem[i] = '0;
		// ROM region, word address 101x_xxxx...
		for (int w = 20'hA0000; w <= 20'hBFFFF; w++)
			mem[w] = {rom_byte({w[19:0], 1'b1}), rom_byte({w[19:0], 1'b0})};
	end

	always @(posedge clk_sys) begin
		if (reset) begin
			ack_o <= 1'b0;
			busy  <= 1'b0;
			cnt   <= '0;
		end else if (!busy && (sdram_i.req != ack_o)) begin
			busy <= 1'b1;
			rng  = xorshift32(rng);
			cnt  <= 5'(rng % 6) + 5'd1 + (slow_i ? 5'd10 : 5'd0);
		end else if (busy) begin
			if (cnt == 5'd1) begin
				if (sdram_i.we) begin
					if (sdram_i.ds[0]) mem[sdram_i.addr][7:0]  <= sdram_i.data[7:0];
					if (sdram_i.ds[1]) mem[sdram_i.addr][15:8] <= sdram_i.data[15:8];
				end
				q_o   <= mem[sdram_i.addr];
				ack_o <= ~ack_o;
				busy  <= 1'b0;
			end
			cnt <= cnt - 5'd1;
		end
	end

endmodule

/* sim/tb_zxmem.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module tb_zxmem;

	logic                  clk_sys;
	logic                  reset;
	zxmem_pkg::mem_mode_e  mode;
	zxmem_pkg::cpu_bus_t   cpu_bus;
	logic [7:0]            cpu_din;
	logic                  cpu_ready;
	zxmem_pkg::ula_out_t   ula;
	zxmem_pkg::sdram_bus_t sdram;
	logic                  sdram_ack;
	logic [15:0]           sdram_q;
	logic                  slow;
	logic                  run_done;
	logic [31:0]           rng;
	int                    cycles;

	// Reference model state
	logic [2:0]           m_bank;
	logic                 m_rom0;
	logic                 m_rom1;
	logic                 m_special;
	logic                 m_locked;
	logic [1:0]           m_cfg;
	zxmem_pkg::mem_mode_e m_mode;
	zxmem_pkg::ula_out_t  m_ula;
	logic [7:0]           ram_m [0:131071];

	localparam logic [2:0] SPEC_TAB [0:15] = '{0, 1, 2, 3, 4, 5, 6, 7, 4, 5, 6, 3, 4, 7, 6, 3};

	zxmem_top UUT (
		.clk_sys(clk_sys), .reset(reset), .mode_i(mode), .cpu_bus_i(cpu_bus),
		.cpu_din_o(cpu_din), .cpu_ready_o(cpu_ready), .ula_o(ula), .sdram_o(sdram),
		.sdram_ack_i(sdram_ack), .sdram_q_i(sdram_q)
	);

	sdram_model u_mem (
		.clk_sys(clk_sys), .reset(reset), .sdram_i(sdram), .slow_i(slow),
		.ack_o(sdram_ack), .q_o(sdram_q)
	);

	bind zxmem_top zxmem_props u_props (
		.clk_sys(clk_sys), .reset(reset), .cpu_ready_o(cpu_ready_o),
		.sdram_o(sdram_o), .sdram_ack_i(sdram_ack_i)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic fail_now(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		$display("TB FAILED");
		run_done = 1'b1;
		$fatal(1, "stopping on first error");
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= 3000) begin
			$display("Timeout: the run went past 3000 clock cycles");
			$display("TB FAILED");
			run_done = 1'b1;
			$fatal(1, "timeout");
		end
	end

	final if (!run_done) $display("TB FAILED");

	task automatic tick;
		@(posedge clk_sys);
		#2;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [20:0] exp_phys(input logic [15:0] a);
		logic [1:0] s;
		logic [2:0] b;
		logic [3:0] pg;
		s = a[15:14];
		if (m_special)
			b = SPEC_TAB[{m_cfg, s}];
		else if (s == 2'd0) begin
			if (m_mode == zxmem_pkg::MODE_PLUS3)
				pg = {2'b10, m_rom1, m_rom0};
			else if (m_mode == zxmem_pkg::MODE_48)
				pg = 4'b1111;
			else
				pg = {3'b011, m_rom0};
			return {`ZX_ROM_REGION, pg, a[13:0]};
		end else
			b = (s == 2'd1) ? 3'd5 : (s == 2'd2) ? 3'd2 : m_bank;
		return {4'b0000, b, a[13:0]};
	endfunction

	task automatic reset_dut(input zxmem_pkg::mem_mode_e md);
		reset = 1'b1;
		mode = md;
		cpu_bus = '0;
		repeat (5) tick();
		reset = 1'b0;
		{m_bank, m_rom0, m_rom1, m_special, m_locked, m_cfg} = '0;
		m_mode = md;
		m_ula = '0;
	endtask

	// Port write, also checks the ULA latch timing
	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		zxmem_pkg::ula_out_t prev;
		logic blk;
		prev = ula;
		blk = m_locked | (m_mode == zxmem_pkg::MODE_48);
		if (!blk && !a[15] && !a[1] && (a[14] || m_mode != zxmem_pkg::MODE_PLUS3)) begin
			m_bank = d[2:0];
			m_rom0 = d[4];
			m_locked = d[5];
		end
		if (!blk && m_mode == zxmem_pkg::MODE_PLUS3 && a[12] && a[15:13] == 3'b000 && !a[1]) begin
			m_special = d[0];
			m_cfg = d[2:1];
			m_rom1 = d[2];
		end
		if (!a[0])
			m_ula = '{border: d[2:0], ear: d[4], mic: d[3]};
		cpu_bus = '0;
		cpu_bus.addr = a;
		cpu_bus.dout = d;
		cpu_bus.iorq = 1'b1;
		cpu_bus.wr = 1'b1;
		tick();   // Sampling edge
		cpu_bus = '0;
		tick();
		assert (ula == prev) else fail_now("ula_o changed one cycle early");
		tick();
		assert (ula == m_ula)
		else fail_now($sformatf("ula_o %h expected %h", ula, m_ula));
	endtask

	task automatic start_mem(input logic [15:0] a, input logic wr, input logic [7:0] d,
		output logic [7:0] exp);
		logic [20:0] p;
		p = exp_phys(a);
		if (p[20:18] == `ZX_ROM_REGION)
			exp = p[7:0] ^ p[15:8] ^ {3'b000, p[20:16]};
		else begin
			exp = ram_m[p[16:0]];
			if (wr)
				ram_m[p[16:0]] = d;
		end
		cpu_bus = '0;
		cpu_bus.addr = a;
		cpu_bus.dout = d;
		cpu_bus.mreq = 1'b1;
		cpu_bus.rd = ~wr;
		cpu_bus.wr = wr;
		tick();
		tick();
		assert (!cpu_ready) else fail_now("memory cycle did not lower cpu_ready_o");
	endtask

	task automatic finish_mem(input logic [15:0] a, input logic wr, input logic [7:0] exp);
		while (!cpu_ready)
			tick();
		if (!wr) begin
			assert (cpu_din == exp)
			else fail_now($sformatf("read %h got %h expected %h", a, cpu_din, exp));
		end
		cpu_bus = '0;
		tick();
	endtask

	task automatic mem_op(input logic [15:0] a, input logic wr, input logic [7:0] d);
		logic [7:0] exp;
		start_mem(a, wr, d, exp);
		finish_mem(a, wr, exp);
	endtask

	task automatic rand_rw(input logic [1:0] slot);
		rng = xorshift32(rng);
		mem_op({slot, rng[13:0]}, 1'b1, rng[23:16]);
		mem_op({slot, rng[13:0]}, 1'b0, 8'h00);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	initial begin
		logic [7:0] exp;
		reset = 1'b1;
		mode = zxmem_pkg::MODE_128;
		cpu_bus = '0;
		slow = 1'b0;
		run_done = 1'b0;
		cycles = 0;
		rng = 32'h37c21898;
		for (int i = 0; i < 131072; i++)
			ram_m[i] = 8'h00;

		// 128K banks through all three RAM slots
		reset_dut(zxmem_pkg::MODE_128);
		for (int b = 0; b < 8; b++) begin
			io_write(16'h7FFD, 8'(b));
			for (int k = 1; k < 4; k++)
				rand_rw(2'(k));
			mem_op(16'hC300, 1'b1, 8'(64 + b));   // Marker per bank
		end
		mem_op(16'h8300, 1'b1, 8'h2C);   // Bank 2 through slot 2
		for (int b = 0; b < 8; b++) begin
			io_write(16'h7FFD, 8'(b));
			mem_op(16'hC300, 1'b0, 8'h00);
		end
		mem_op(16'h4123, 1'b1, 8'h5A);
		io_write(16'h7FFD, 8'h05);
		mem_op(16'hC123, 1'b0, 8'h00);

		// Slot 0 writes are dropped, ROM shows through
		mem_op(16'h0010, 1'b1, 8'hAA);
		mem_op(16'h0010, 1'b0, 8'h00);
		io_write(16'h7FFD, 8'h10);
		mem_op(16'h0010, 1'b1, 8'h55);
		mem_op(16'h0010, 1'b0, 8'h00);

		// Lock bit, then reset releases it
		io_write(16'h7FFD, 8'h06);
		mem_op(16'hC040, 1'b1, 8'h66);
		io_write(16'h7FFD, 8'h23);
		mem_op(16'hC040, 1'b1, 8'h33);
		io_write(16'h7FFD, 8'h06);
		mem_op(16'hC040, 1'b0, 8'h00);
		reset_dut(zxmem_pkg::MODE_128);
		io_write(16'h7FFD, 8'h06);
		mem_op(16'hC040, 1'b0, 8'h00);
		io_write(16'h7FFD, 8'h07);
		mem_op(16'hC040, 1'b1, 8'h77);

		// +3 special configurations and four ROMs
		reset_dut(zxmem_pkg::MODE_PLUS3);
		for (int c = 0; c < 4; c++) begin
			io_write(16'h1FFD, 8'((c << 1) | 1));
			for (int k = 0; k < 4; k++) begin
				mem_op({2'(k), 14'h0300}, 1'b0, 8'h00);   // Last marker left in this bank
				mem_op({2'(k), 14'h0300}, 1'b1, 8'((c << 4) | k | 128));
			end
		end
		for (int rs = 0; rs < 4; rs++) begin
			io_write(16'h1FFD, 8'((rs & 2) << 1));
			io_write(16'h7FFD, 8'((rs & 1) << 4));
			mem_op(16'h1234, 1'b0, 8'h00);
		end

		// 48K ignores 7FFD
		reset_dut(zxmem_pkg::MODE_48);
		mem_op(16'hC040, 1'b1, 8'h48);
		io_write(16'h7FFD, 8'h17);
		mem_op(16'hC040, 1'b0, 8'h00);
		mem_op(16'h2345, 1'b0, 8'h00);

		// Port FE, alone and behind a slow read
		reset_dut(zxmem_pkg::MODE_128);
		for (int k = 0; k < 4; k++) begin
			rng = xorshift32(rng);
			io_write({rng[15:1], 1'b0}, rng[23:16]);
		end
		slow = 1'b1;
		start_mem(16'h8001, 1'b0, 8'h00, exp);
		io_write(16'h00FE, 8'h1D);
		finish_mem(16'h8001, 1'b0, exp);
		slow = 1'b0;

		// Port reads float high
		cpu_bus.addr = 16'h00FE;
		cpu_bus.iorq = 1'b1;
		cpu_bus.rd = 1'b1;
		tick();
		cpu_bus = '0;
		repeat (4) tick();
		assert (cpu_din == `ZX_PORT_IDLE)
		else fail_now($sformatf("port read got %h", cpu_din));

		run_done = 1'b1;
		$display("TB PASSED");
		$finish;
	end

endmodule

/* sim/zxmem_props.sv */
`timescale 1ns/1ps
`include "zxmem_params.svh"

module zxmem_props (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  cpu_ready_o,
	input zxmem_pkg::sdram_bus_t sdram_o,
	input logic                  sdram_ack_i
);

	// New request only once the previous one is acknowledged
	req_toggle_idle: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(sdram_o.req) |-> $past(sdram_o.req == sdram_ack_i))
		else $error("req toggled while a request was outstanding");

	// ROM is never written
	no_rom_write: assert property (@(posedge clk_sys) disable iff (reset)
		($changed(sdram_o.req) && sdram_o.we) |->
		(sdram_o.addr[`ZX_SD_AW-1 -: 3] != `ZX_ROM_REGION))
		else $error("SDRAM write into the ROM region");

	ready_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> cpu_ready_o)
		else $error("cpu_ready_o low right after reset");

endmodule
